//--- hdl/exLanePkg.sv
// Lane micro-op and ALU operation enums, null register id
`default_nettype none

package exLanePkg;

	// Micro-op command, 4 bits
	// Codes 7 to 15 are not handled by this lane
	typedef enum logic [3:0] {
		UCmdNop   = 4'h0,	// No operation, forwards EX1 decision
		UCmdMovIr = 4'h1,	// Immediate load into Rm
		UCmdAlu3  = 4'h2,	// Rm = Rs op Rt
		UCmdMulW3 = 4'h3,	// Rm = signed low words of Rs * Rt
		UCmdShad3 = 4'h4,	// Rm = Rs shifted by signed Rt
		UCmdLoad  = 4'h5,	// Data comes back in a later stage
		UCmdStore = 4'h6	// No register write
	} exUCmd;

	// ALU operation, low 3 bits of opUIxt
	typedef enum logic [2:0] {
		AluAdd = 3'h0,
		AluSub = 3'h1,
		AluAnd = 3'h2,
		AluOr  = 3'h3,
		AluXor = 3'h4	// Codes 5 to 7 give zero
	} exAluOp;

	// Null destination, means no write
	localparam logic [5:0] regIdZzr = 6'd0;

endpackage

`default_nettype wire

//--- hdl/exAlu.sv
// Combinational lane ALU: add, subtract, and, or, xor
`timescale 1ns/1ps
`default_nettype none

module exAlu (
	input  exLanePkg::exAluOp aluOp,	// Operation select
	input  logic [63:0]       srcA,		// Source A, from Rs
	input  logic [63:0]       srcB,		// Source B, from Rt
	output logic [63:0]       aluRes	// Result, zero latency
);
	import exLanePkg::*;

	logic [63:0] sumRes;	// Shared add/sub path
	logic        doSub;

	// Subtract as add of the inverted operand plus carry in
	assign doSub  = (aluOp == AluSub);
	assign sumRes = srcA + (doSub ? ~srcB : srcB) + {63'd0, doSub};

	always_comb begin
		case (aluOp)
			AluAdd: begin
				aluRes = sumRes;
			end
			AluSub: begin
				aluRes = sumRes;
			end
			AluAnd: begin
				aluRes = srcA & srcB;
			end
			AluOr: begin
				aluRes = srcA | srcB;
			end
			AluXor: begin
				aluRes = srcA ^ srcB;
			end
			default: begin
				aluRes = 64'd0;	// Unlisted codes
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/exMulW.sv
// Two-stage signed 32x32 word multiplier, partial products in EX1, sum in EX2
`timescale 1ns/1ps
`default_nettype none

module exMulW (
	input  logic        clock,
	input  logic        arstN,
	input  logic [63:0] srcA,		// Rs at EX1, low word used
	input  logic [63:0] srcB,		// Rt at EX1, low word used
	output logic [63:0] mulWRes		// Signed product, valid in EX2
);
	logic signed [15:0] aHi;		// Signed upper halves
	logic signed [15:0] bHi;
	logic        [15:0] aLo;		// Unsigned lower halves
	logic        [15:0] bLo;
	logic        [31:0] ppLoLo;		// EX1/EX2 partial products
	logic signed [32:0] ppLoHi;
	logic signed [32:0] ppHiLo;
	logic signed [31:0] ppHiHi;
	logic        [63:0] extLoHi;	// Sign extended middle terms
	logic        [63:0] extHiLo;

	assign aHi = srcA[31:16];
	assign aLo = srcA[15:0];
	assign bHi = srcB[31:16];
	assign bLo = srcB[15:0];

	// New multiply may start every cycle
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ppLoLo <= '0;
			ppLoHi <= '0;
			ppHiLo <= '0;
			ppHiHi <= '0;
		end else begin
			ppLoLo <= aLo * bLo;
			ppLoHi <= $signed({1'b0, aLo}) * bHi;	// Unsigned low x signed high
			ppHiLo <= aHi * $signed({1'b0, bLo});
			ppHiHi <= aHi * bHi;
		end
	end

	assign extLoHi = ppLoHi;
	assign extHiLo = ppHiLo;

	// EX2 sum of the weighted terms
	assign mulWRes = {ppHiHi, 32'd0} + (extLoHi << 16) + (extHiLo << 16) + {32'd0, ppLoLo};

endmodule

`default_nettype wire

//--- hdl/exStage1.sv
// EX1 stage: operand use, immediate and shift handling, EX1-to-EX2 pipeline register
`timescale 1ns/1ps
`default_nettype none

module exStage1 #(
	parameter int ImmWidth = 33		// Decoded immediate width, 9 to 64
) (
	input  logic                 clock,
	input  logic                 arstN,
	input  exLanePkg::exUCmd     opUCmd,		// Micro-op at EX1
	input  logic [5:0]           opUIxt,		// Low 3 bits select ALU op
	input  logic [5:0]           regIdRm,		// Destination id
	input  logic [63:0]          regValRs,		// Source A value
	input  logic [63:0]          regValRt,		// Source B value
	input  logic [ImmWidth-1:0]  regValImm,		// Immediate from decode
	input  logic                 opBraFlush,	// Branch taken this cycle
	output exLanePkg::exUCmd     ex2UCmd,
	output logic [5:0]           ex2IdRm,
	output logic [5:0]           ex2IdRn1,		// EX1 write decision, id
	output logic [63:0]          ex2ValRn1,		// EX1 write decision, value
	output logic [63:0]          ex2AluRes,
	output logic [63:0]          ex2DelayVal	// Registered shift result
);
	import exLanePkg::*;

	exAluOp             aluOp;
	logic [63:0]        aluRes;
	logic [63:0]        immExt;		// Sign extended immediate
	logic signed [6:0]  shAmt;		// Signed shift amount
	logic [6:0]         shMag;		// Magnitude for right shift
	logic [63:0]        shRes;
	logic [5:0]         ex1IdRn1;
	logic [63:0]        ex1ValRn1;

	assign aluOp = exAluOp'(opUIxt[2:0]);

	exAlu exAlu_inst (
		.aluOp  (aluOp),
		.srcA   (regValRs),
		.srcB   (regValRt),
		.aluRes (aluRes)
	);

	assign immExt = $signed(regValImm);	// Extends to 64 bits

	// Positive amount shifts left, negative shifts right arithmetic
	assign shAmt = regValRt[6:0];
	assign shMag = -shAmt;				// -64 wraps to 64, unsigned use
	assign shRes = shAmt[6] ? 64'($signed(regValRs) >>> shMag) : (regValRs << shAmt[5:0]);

	// EX1 own write, only immediate loads finish here
	always_comb begin
		ex1IdRn1  = regIdZzr;
		ex1ValRn1 = 64'd0;
		case (opUCmd)
			UCmdMovIr: begin
				ex1IdRn1  = regIdRm;
				ex1ValRn1 = immExt;
			end
			default: begin
			end
		endcase
	end

	// Control part of the pipeline register
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ex2UCmd  <= UCmdNop;
			ex2IdRm  <= regIdZzr;
			ex2IdRn1 <= regIdZzr;
		end else if (opBraFlush) begin
			ex2UCmd  <= UCmdNop;	// Killed op enters EX2 as Nop
			ex2IdRm  <= regIdZzr;
			ex2IdRn1 <= regIdZzr;
		end else begin
			ex2UCmd  <= opUCmd;
			ex2IdRm  <= regIdRm;
			ex2IdRn1 <= ex1IdRn1;
		end
	end

	// Payload part, no reset
	always_ff @(posedge clock) begin
		ex2ValRn1   <= ex1ValRn1;
		ex2AluRes   <= aluRes;
		ex2DelayVal <= shRes;	// Shift finishes in EX2
	end

endmodule

`default_nettype wire

//--- hdl/exStage2.sv
// EX2 stage: destination select, held marking, flush kill and fault strobe
`timescale 1ns/1ps
`default_nettype none

module exStage2 (
	input  logic              clock,
	input  logic              arstN,
	input  exLanePkg::exUCmd  ex2UCmd,		// Micro-op now in EX2
	input  logic [5:0]        ex2IdRm,		// Its destination id
	input  logic [5:0]        ex2IdRn1,		// EX1 write decision, id
	input  logic [63:0]       ex2ValRn1,	// EX1 write decision, value
	input  logic [63:0]       ex2AluRes,	// ALU result from EX1
	input  logic [63:0]       ex2DelayVal,	// Shift result from EX1
	input  logic [63:0]       mulWRes,		// Multiplier sum
	input  logic              opBraFlush,	// Branch taken this cycle
	output logic [5:0]        regIdRn2,		// Lane destination id
	output logic [63:0]       regValRn2,	// Lane destination value
	output logic              regHeld,		// Data comes from a later stage
	output logic              opFault		// First cycle of unhandled run
);
	import exLanePkg::*;

	logic        doOvr;			// Result finishes in EX2
	logic [63:0] ovrVal;
	logic        unhandled;
	logic        faultLatch;	// Previous op was unhandled

	// Decode which result completes here
	always_comb begin
		doOvr     = 1'b0;
		ovrVal    = 64'd0;
		regHeld   = 1'b0;
		unhandled = 1'b0;
		case (ex2UCmd)
			UCmdNop: begin
			end
			UCmdStore: begin
			end
			UCmdMovIr: begin
				// Written by EX1, forward only
			end
			UCmdAlu3: begin
				doOvr  = 1'b1;
				ovrVal = ex2AluRes;
			end
			UCmdMulW3: begin
				doOvr  = 1'b1;
				ovrVal = mulWRes;
			end
			UCmdShad3: begin
				doOvr  = 1'b1;
				ovrVal = ex2DelayVal;
			end
			UCmdLoad: begin
				regHeld = 1'b1;
			end
			default: begin
				unhandled = 1'b1;
			end
		endcase
	end

	// Forward by default, override, then flush kill last
	always_comb begin
		regIdRn2  = ex2IdRn1;
		regValRn2 = ex2ValRn1;
		if (doOvr) begin
			regIdRn2  = ex2IdRm;
			regValRn2 = ovrVal;
		end
		if (opBraFlush) begin
			regIdRn2 = regIdZzr;
		end
	end

	// Strobe once per run of unhandled codes
	assign opFault = unhandled & ~faultLatch;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			faultLatch <= 1'b0;
		end else begin
			faultLatch <= unhandled;
		end
	end

endmodule

`default_nettype wire

//--- hdl/exLane.sv
// Lane top level: EX1 stage, word multiplier and EX2 stage
`timescale 1ns/1ps
`default_nettype none

module exLane #(
	parameter int ImmWidth = 33		// Decoded immediate width
) (
	input  logic                 clock,
	input  logic                 arstN,
	input  exLanePkg::exUCmd     opUCmd,		// Micro-op at EX1
	input  logic [5:0]           opUIxt,		// Op extension
	input  logic [5:0]           regIdRs,		// Source A id, trace only
	input  logic [5:0]           regIdRt,		// Source B id, trace only
	input  logic [5:0]           regIdRm,		// Destination id
	input  logic [63:0]          regValRs,
	input  logic [63:0]          regValRt,
	input  logic [ImmWidth-1:0]  regValImm,
	input  logic                 opBraFlush,	// Branch taken this cycle
	output logic [5:0]           regIdRn2,		// Result id, one edge later
	output logic [63:0]          regValRn2,
	output logic                 regHeld,
	output logic                 opFault
);
	import exLanePkg::*;

	exUCmd       ex2UCmd;
	logic [5:0]  ex2IdRm;
	logic [5:0]  ex2IdRn1;
	logic [63:0] ex2ValRn1;
	logic [63:0] ex2AluRes;
	logic [63:0] ex2DelayVal;
	logic [63:0] mulWRes;

	exStage1 #(
		.ImmWidth (ImmWidth)
	) exStage1_inst (
		.clock       (clock),
		.arstN       (arstN),
		.opUCmd      (opUCmd),
		.opUIxt      (opUIxt),
		.regIdRm     (regIdRm),
		.regValRs    (regValRs),
		.regValRt    (regValRt),
		.regValImm   (regValImm),
		.opBraFlush  (opBraFlush),
		.ex2UCmd     (ex2UCmd),
		.ex2IdRm     (ex2IdRm),
		.ex2IdRn1    (ex2IdRn1),
		.ex2ValRn1   (ex2ValRn1),
		.ex2AluRes   (ex2AluRes),
		.ex2DelayVal (ex2DelayVal)
	);

	// Operands taken at EX1, product seen in EX2
	exMulW exMulW_inst (
		.clock   (clock),
		.arstN   (arstN),
		.srcA    (regValRs),
		.srcB    (regValRt),
		.mulWRes (mulWRes)
	);

	exStage2 exStage2_inst (
		.clock       (clock),
		.arstN       (arstN),
		.ex2UCmd     (ex2UCmd),
		.ex2IdRm     (ex2IdRm),
		.ex2IdRn1    (ex2IdRn1),
		.ex2ValRn1   (ex2ValRn1),
		.ex2AluRes   (ex2AluRes),
		.ex2DelayVal (ex2DelayVal),
		.mulWRes     (mulWRes),
		.opBraFlush  (opBraFlush),
		.regIdRn2    (regIdRn2),
		.regValRn2   (regValRn2),
		.regHeld     (regHeld),
		.opFault     (opFault)
	);

endmodule

`default_nettype wire

//--- sim/exLane_checker.sv
// Bound lane checker: reference rules, reference EX2 pipeline, output assertions, error count
`timescale 1ns/1ps
`default_nettype none

module exLane_checker #(
	parameter int ImmWidth = 33
) (
	input  logic                 clock,
	input  logic                 arstN,
	input  exLanePkg::exUCmd     opUCmd,
	input  logic [5:0]           opUIxt,
	input  logic [5:0]           regIdRm,
	input  logic [63:0]          regValRs,
	input  logic [63:0]          regValRt,
	input  logic [ImmWidth-1:0]  regValImm,
	input  logic                 opBraFlush,
	input  logic [5:0]           regIdRn2,
	input  logic [63:0]          regValRn2,
	input  logic                 regHeld,
	input  logic                 opFault
);
	import exLanePkg::*;

	int errCount = 0;				// Read by the testbench

	logic [3:0]          refCmd;		// Op expected in EX2
	logic [3:0]          refPrevCmd;	// EX2 op one cycle earlier
	logic [2:0]          pastAluOp;
	logic [5:0]          pastRm;
	logic [63:0]         pastRs;
	logic [63:0]         pastRt;
	logic [ImmWidth-1:0] pastImm;
	logic [63:0]         expVal;		// Expected regValRn2
	logic                expFault;

	function automatic logic [63:0] aluRule(logic [2:0] op, logic [63:0] a, logic [63:0] b);
		case (op)
			AluAdd:  return a + b;
			AluSub:  return a - b;
			AluAnd:  return a & b;
			AluOr:   return a | b;
			AluXor:  return a ^ b;
			default: return 64'd0;
		endcase
	endfunction

	// Signed product of the low words
	function automatic logic [63:0] mulRule(logic [63:0] a, logic [63:0] b);
		longint sa;
		longint sb;
		sa = $signed(a[31:0]);
		sb = $signed(b[31:0]);
		return sa * sb;
	endfunction

	// Positive amount left, negative amount arithmetic right
	function automatic logic [63:0] shiftRule(logic [63:0] v, logic [6:0] amt);
		int                 n;
		logic signed [63:0] sv;
		n  = $signed(amt);
		sv = v;
		if (n >= 0) begin
			return v << n;
		end
		return sv >>> (-n);
	endfunction

	function automatic logic [63:0] immRule(logic [ImmWidth-1:0] imm);
		logic [63:0] r;
		for (int i = 0; i < 64; i++) begin
			r[i] = (i < ImmWidth) ? imm[i] : imm[ImmWidth-1];	// Copy sign bit upward
		end
		return r;
	endfunction

	function automatic logic isUnhandled(logic [3:0] cmd);
		return cmd > UCmdStore;		// Codes 7 to 15
	endfunction

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			refCmd     <= UCmdNop;
			refPrevCmd <= UCmdNop;
			pastAluOp  <= '0;
			pastRm     <= regIdZzr;
			pastRs     <= '0;
			pastRt     <= '0;
			pastImm    <= '0;
		end else begin
			refCmd     <= opBraFlush ? UCmdNop : opUCmd;	// Flushed op enters as Nop
			refPrevCmd <= refCmd;
			pastAluOp  <= opUIxt[2:0];
			pastRm     <= regIdRm;
			pastRs     <= regValRs;
			pastRt     <= regValRt;
			pastImm    <= regValImm;
		end
	end

	always_comb begin
		case (refCmd)
			UCmdMovIr: expVal = immRule(pastImm);
			UCmdAlu3:  expVal = aluRule(pastAluOp, pastRs, pastRt);
			UCmdMulW3: expVal = mulRule(pastRs, pastRt);
			UCmdShad3: expVal = shiftRule(pastRs, pastRt[6:0]);
			default:   expVal = 64'd0;
		endcase
	end

	assign expFault = isUnhandled(refCmd) && !isUnhandled(refPrevCmd);	// First of a run

	aResult: assert property (@(posedge clock) disable iff (!arstN)
		refCmd inside {UCmdMovIr, UCmdAlu3, UCmdMulW3, UCmdShad3} && !opBraFlush
		|-> regIdRn2 == pastRm && regValRn2 == expVal && !regHeld)
	else begin
		errCount++;
		$error("FAILED regIdRn2/regValRn2 got %h/%h expected %h/%h", $sampled(regIdRn2),
			$sampled(regValRn2), $sampled(pastRm), $sampled(expVal));
	end

	aLoad: assert property (@(posedge clock) disable iff (!arstN)
		refCmd == UCmdLoad |-> regHeld && regIdRn2 == regIdZzr)
	else begin
		errCount++;
		$error("FAILED regHeld/regIdRn2 got %h/%h expected 1/00", $sampled(regHeld),
			$sampled(regIdRn2));
	end

	// Nop also covers an op flushed at EX1 and the quiet time after reset
	aQuiet: assert property (@(posedge clock) disable iff (!arstN)
		refCmd inside {UCmdNop, UCmdStore} || isUnhandled(refCmd)
		|-> !regHeld && regIdRn2 == regIdZzr)
	else begin
		errCount++;
		$error("FAILED regHeld/regIdRn2 got %h/%h expected 0/00", $sampled(regHeld),
			$sampled(regIdRn2));
	end

	aFlushNow: assert property (@(posedge clock) disable iff (!arstN)
		opBraFlush |-> regIdRn2 == regIdZzr)
	else begin
		errCount++;
		$error("FAILED regIdRn2 got %h expected 00 under flush", $sampled(regIdRn2));
	end

	aFault: assert property (@(posedge clock) disable iff (!arstN)
		opFault == expFault)
	else begin
		errCount++;
		$error("FAILED opFault got %h expected %h", $sampled(opFault), $sampled(expFault));
	end

endmodule

bind exLane exLane_checker #(.ImmWidth(ImmWidth)) exLane_checker_inst (.*);

`default_nettype wire

//--- sim/exLaneTb.sv
// Lane testbench: clock, reset, LFSR micro-op stimulus, directed runs, closing report
`timescale 1ns/1ps
`default_nettype none

module exLaneTb;
	import exLanePkg::*;

	localparam int ImmWidth   = 33;
	localparam int RandCycles = 2000;
	localparam int ResetWait  = 20;		// Cycles allowed to leave reset

	logic                clock;
	logic                arstN;
	exUCmd               opUCmd;
	logic [5:0]          opUIxt;
	logic [5:0]          regIdRs;
	logic [5:0]          regIdRt;
	logic [5:0]          regIdRm;
	logic [63:0]         regValRs;
	logic [63:0]         regValRt;
	logic [ImmWidth-1:0] regValImm;
	logic                opBraFlush;
	logic [5:0]          regIdRn2;
	logic [63:0]         regValRn2;
	logic                regHeld;
	logic                opFault;
	logic [15:0]         lfsr;			// Stimulus generator state
	int                  timeoutCount;
	int                  checkErrors;
	logic                resetDone;

	exLane #(
		.ImmWidth (ImmWidth)
	) exLane_inst (
		.clock      (clock),
		.arstN      (arstN),
		.opUCmd     (opUCmd),
		.opUIxt     (opUIxt),
		.regIdRs    (regIdRs),
		.regIdRt    (regIdRt),
		.regIdRm    (regIdRm),
		.regValRs   (regValRs),
		.regValRt   (regValRt),
		.regValImm  (regValImm),
		.opBraFlush (opBraFlush),
		.regIdRn2   (regIdRn2),
		.regValRn2  (regValRn2),
		.regHeld    (regHeld),
		.opFault    (opFault)
	);

	always #50 clock = ~clock;	// 100 ns period

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic logic [63:0] randBits(int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	// One op per rising edge, operands fresh from the LFSR
	task automatic driveOp(input logic [3:0] cmd, input logic flush);
		@(posedge clock);
		opUCmd     <= exUCmd'(cmd);
		opUIxt     <= 6'(randBits(6));
		regIdRs    <= 6'(randBits(6));
		regIdRt    <= 6'(randBits(6));
		regIdRm    <= 6'(randBits(6));
		regValRs   <= randBits(64);
		regValRt   <= randBits(64);
		regValImm  <= ImmWidth'(randBits(ImmWidth));
		opBraFlush <= flush;
	endtask

	task automatic randomOp();
		logic [3:0] cmd;
		logic       flush;
		flush = (randBits(3) == 0);			// About one in eight
		if (randBits(7) < 13) begin
			cmd = 4'(7 + randBits(4) % 9);	// Unhandled, about one in ten
		end else begin
			cmd = 4'(randBits(3) % 7);
		end
		driveOp(cmd, flush);
	endtask

	task automatic waitResetDone(output logic done);
		int n;
		done = 1'b0;
		n    = 0;
		while (!done && n < ResetWait) begin
			@(negedge clock);
			done = arstN && regIdRn2 == regIdZzr && !regHeld && !opFault;
			n++;
		end
		if (!done) begin
			timeoutCount++;
			$display("Timeout: lane outputs not quiet %0d cycles after reset", ResetWait);
		end
	endtask

	initial begin
		clock        = 1'b0;
		arstN        = 1'b0;
		opUCmd       = UCmdNop;
		opUIxt       = '0;
		regIdRs      = '0;
		regIdRt      = '0;
		regIdRm      = '0;
		regValRs     = '0;
		regValRt     = '0;
		regValImm    = '0;
		opBraFlush   = 1'b0;
		lfsr         = 16'd19649;
		timeoutCount = 0;
		repeat (8) @(posedge clock);
		arstN <= 1'b1;
		waitResetDone(resetDone);
		if (resetDone) begin
			for (int c = 0; c < RandCycles; c++) begin
				randomOp();
			end
			repeat (4) driveOp(4'd9, 1'b0);		// Fault only on the first
			driveOp(UCmdNop, 1'b0);
			repeat (3) driveOp(4'd15, 1'b0);
			driveOp(UCmdAlu3, 1'b0);
			repeat (2) driveOp(4'd7, 1'b0);
			repeat (4) driveOp(UCmdAlu3, 1'b1);	// Back-to-back flushes
			driveOp(UCmdMulW3, 1'b0);
			driveOp(UCmdShad3, 1'b1);
			driveOp(UCmdMovIr, 1'b0);
			repeat (3) driveOp(UCmdNop, 1'b0);	// Drain both stages
		end
		@(negedge clock);
		checkErrors = exLane_inst.exLane_checker_inst.errCount;
		$display("Closing: %0d assertion failures, %0d timeouts", checkErrors, timeoutCount);
		if (checkErrors == 0 && timeoutCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- exLane.f
hdl/exLanePkg.sv
hdl/exAlu.sv
hdl/exMulW.sv
hdl/exStage1.sv
hdl/exStage2.sv
hdl/exLane.sv
sim/exLane_checker.sv
sim/exLaneTb.sv

//--- Bender.yml
package:
  name: exLane

sources:
  - files:
      - hdl/exLanePkg.sv
      - hdl/exAlu.sv
      - hdl/exMulW.sv
      - hdl/exStage1.sv
      - hdl/exStage2.sv
      - hdl/exLane.sv
  - target: simulation
    files:
      - sim/exLane_checker.sv
      - sim/exLaneTb.sv
